/* Bender.yml */
package:
  name: music_core

sources:
  # Design, package first
  - files:
      - logic/music_pkg.sv
      - logic/sample_if.sv
      - logic/note_synth.sv
      - logic/sample_fifo.sv
      - logic/codec_serializer.sv
      - logic/music_core_top.sv

  # Testbench and bound checker
  - target: test
    files:
      - testbench/music_core_chk.sv
      - testbench/music_core_tb.sv

/* all.f */
logic/music_pkg.sv
logic/sample_if.sv
logic/note_synth.sv
logic/sample_fifo.sv
logic/codec_serializer.sv
logic/music_core_top.sv
testbench/music_core_chk.sv
testbench/music_core_tb.sv

/* logic/codec_serializer.sv */
`timescale 1ns/1ps

module codec_serializer import music_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    sample_if.receiver link,
    output logic       bclk,
    output logic       lrclk,
    output logic       sdata,
    output logic       underrun
);

    logic [DIV_BITS-1:0]     div_cnt;
    logic                    div_end;
    logic                    shift_en;
    logic                    start_pending;
    logic [BIT_CNT_BITS-1:0] bit_cnt;
    logic [BIT_CNT_BITS-1:0] bit_next;
    logic                    frame_start;
    logic                    take;
    sample_t                 frame_sample;
    logic [SLOT_BITS-1:0]    slot_sr;

    // ==========================================================
    // Bit clock
    // ==========================================================

    assign div_end = (div_cnt == DIV_BITS'(BCLK_DIV - 1));

    // bclk toggles every BCLK_DIV cycles,
    // shift_en pulses the cycle after each falling edge
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt  <= '0;
            bclk     <= 1'b0;
            shift_en <= 1'b0;
        end else begin
            shift_en <= div_end && bclk;
            if (div_end) begin
                div_cnt <= '0;
                bclk    <= ~bclk;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // ==========================================================
    // Frame sequencing
    // ==========================================================

    // First frame opens right after reset, later ones after bit 47
    assign frame_start = start_pending
                         || (shift_en && bit_cnt == BIT_CNT_BITS'(FRAME_BITS - 1));
    assign bit_next    = bit_cnt + 1'b1;

    // Pending sample from the FIFO
    assign take = link.req && !link.ack;

    // Rest notes and underruns both send silence
    assign frame_sample = (take && !link.rest) ? link.sample : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            start_pending <= 1'b1;
            bit_cnt       <= '0;
            lrclk         <= 1'b0;
            sdata         <= 1'b0;
            underrun      <= 1'b0;
        end else begin
            start_pending <= 1'b0;
            if (frame_start) begin
                bit_cnt  <= '0;
                lrclk    <= 1'b0;
                sdata    <= frame_sample[SAMPLE_BITS-1];
                // Flag holds for the whole frame
                underrun <= !take;
            end else if (shift_en) begin
                bit_cnt <= bit_next;
                // Right slot from bit 24 on
                lrclk   <= (bit_next >= BIT_CNT_BITS'(SLOT_BITS));
                sdata   <= (bit_next < BIT_CNT_BITS'(SLOT_BITS)) ? slot_sr[SLOT_BITS-2]
                           : 1'b0;
            end
        end
    end

    // Left slot image, sample then padding, MSB first
    always_ff @(posedge clk) begin
        if (frame_start) begin
            slot_sr <= {frame_sample, {PAD_BITS{1'b0}}};
        end else if (shift_en) begin
            slot_sr <= slot_sr << 1;
        end
    end

    // ==========================================================
    // Link handshake
    // ==========================================================

    // Ack at frame start, drop once the FIFO releases req
    always_ff @(posedge clk) begin
        if (reset) begin
            link.ack <= 1'b0;
        end else if (frame_start && take) begin
            link.ack <= 1'b1;
        end else if (link.ack && !link.req) begin
            link.ack <= 1'b0;
        end
    end

endmodule

/* logic/music_core_top.sv */
`timescale 1ns/1ps

module music_core_top import music_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   play,
    input  logic [NOTE_BITS-1:0]   note,
    input  logic [WEIGHT_BITS-1:0] weight,
    output logic                   bclk,
    output logic                   lrclk,
    output logic                   sdata,
    output logic                   underrun
);

    // ==========================================================
    // Sample links
    // ==========================================================

    // Synthesizer to FIFO
    sample_if synth_link ();
    // FIFO to codec serializer
    sample_if codec_link ();

    // ==========================================================
    // Sample path
    // ==========================================================

    // Triangle generator, runs while play is high
    note_synth note_synth (
        .clk    (clk),
        .reset  (reset),
        .play   (play),
        .note   (note),
        .weight (weight),
        .link   (synth_link)
    );

    // Buffer, back-pressures the synthesizer when full
    sample_fifo sample_fifo (
        .clk      (clk),
        .reset    (reset),
        .in_link  (synth_link),
        .out_link (codec_link)
    );

    // One sample per frame onto the serial stream
    codec_serializer codec_serializer (
        .clk      (clk),
        .reset    (reset),
        .link     (codec_link),
        .bclk     (bclk),
        .lrclk    (lrclk),
        .sdata    (sdata),
        .underrun (underrun)
    );

endmodule

/* logic/music_pkg.sv */
package music_pkg;

    // ==========================================================
    // Sample format
    // ==========================================================

    // Signed audio sample as carried on every link
    localparam int SAMPLE_BITS = 18;
    typedef logic signed [SAMPLE_BITS-1:0] sample_t;

    // ==========================================================
    // Note synthesizer
    // ==========================================================

    // Phase accumulator width, top bit picks the falling half
    localparam int PHASE_BITS  = 16;
    // Phase step per note number
    localparam int STEP_UNIT   = 64;
    // Note number width, note 0 is a rest
    localparam int NOTE_BITS   = 6;
    // Attenuation as a right shift of 0..3
    localparam int WEIGHT_BITS = 2;
    // Centers the 15-bit triangle around zero
    localparam int TRI_OFFSET  = 16384;

    // ==========================================================
    // Sample FIFO
    // ==========================================================

    localparam int FIFO_DEPTH = 8;
    localparam int PTR_BITS   = $clog2(FIFO_DEPTH);

    // ==========================================================
    // Serial frame
    // ==========================================================

    // System clocks per bclk half period
    localparam int BCLK_DIV     = 4;
    localparam int DIV_BITS     = $clog2(BCLK_DIV);
    // Bit periods per slot, two slots per frame
    localparam int SLOT_BITS    = 24;
    localparam int FRAME_BITS   = 2 * SLOT_BITS;
    localparam int BIT_CNT_BITS = $clog2(FRAME_BITS);
    // Zero bits after the sample in the left slot
    localparam int PAD_BITS     = SLOT_BITS - SAMPLE_BITS;

endpackage

/* logic/note_synth.sv */
`timescale 1ns/1ps

module note_synth import music_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   play,
    input  logic [NOTE_BITS-1:0]   note,
    input  logic [WEIGHT_BITS-1:0] weight,
    sample_if.sender               link
);

    // Handshake states
    typedef enum logic [1:0] {
        SYN_IDLE,
        SYN_REQ,
        SYN_WAIT
    } syn_state_t;

    syn_state_t              state;
    logic                    play_q;
    logic                    play_rise;
    logic                    start;
    logic                    is_rest;
    logic [PHASE_BITS-1:0]   phase;
    logic [PHASE_BITS-1:0]   step;
    logic [PHASE_BITS-2:0]   tri_mag;
    sample_t                 centered;
    sample_t                 shaped;

    // ==========================================================
    // Triangle shaping
    // ==========================================================

    // Play edge restarts the waveform
    assign play_rise = play & ~play_q;

    // Phase advance per sample, note times step unit
    assign step = PHASE_BITS'(note) * PHASE_BITS'(STEP_UNIT);

    // Lower phase bits, mirrored on the second half
    assign tri_mag = phase[PHASE_BITS-2:0] ^ {(PHASE_BITS-1){phase[PHASE_BITS-1]}};

    // Zero extend, then shift down to a signed range
    assign centered = $signed({{(SAMPLE_BITS-PHASE_BITS+1){1'b0}}, tri_mag})
                      - sample_t'(TRI_OFFSET);

    // Weight as arithmetic attenuation
    assign shaped = centered >>> weight;

    assign is_rest = (note == '0);

    // New sample only once play has been seen for a full cycle,
    // so the cleared phase is the one used
    assign start = (state == SYN_IDLE) && play && play_q && !link.ack;

    // ==========================================================
    // Handshake FSM
    // ==========================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= SYN_IDLE;
            play_q   <= 1'b0;
            link.req <= 1'b0;
        end else begin
            play_q <= play;
            case (state)
                SYN_IDLE: begin
                    if (start) begin
                        link.req <= 1'b1;
                        state    <= SYN_REQ;
                    end
                end
                SYN_REQ: begin
                    // FIFO took the sample
                    if (link.ack) begin
                        link.req <= 1'b0;
                        state    <= SYN_WAIT;
                    end
                end
                SYN_WAIT: begin
                    // Closing phase of the handshake
                    if (!link.ack) begin
                        state <= SYN_IDLE;
                    end
                end
                default: state <= SYN_IDLE;
            endcase
        end
    end

    // Phase, cleared on play edge, stepped after each accepted sample
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= '0;
        end else if (play_rise) begin
            phase <= '0;
        end else if (state == SYN_REQ && link.ack) begin
            phase <= phase + step;
        end
    end

    // Payload latched at request time, stable until the next start
    always_ff @(posedge clk) begin
        if (start) begin
            link.sample <= is_rest ? '0 : shaped;
            link.rest   <= is_rest;
        end
    end

endmodule

/* logic/sample_fifo.sv */
`timescale 1ns/1ps

module sample_fifo import music_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    sample_if.receiver in_link,
    sample_if.sender   out_link
);

    // Write side FSM
    typedef enum logic {
        IN_WAIT_REQ,
        IN_WAIT_DROP
    } in_state_t;

    // Read side FSM
    typedef enum logic [1:0] {
        OUT_IDLE,
        OUT_REQ,
        OUT_WAIT
    } out_state_t;

    in_state_t           in_state;
    out_state_t          out_state;
    sample_t             sample_mem [FIFO_DEPTH];
    logic                rest_mem   [FIFO_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                full;
    logic                empty;
    logic                push;
    logic                pop;
    logic                issue;

    assign full  = (count == (PTR_BITS+1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    // Accept only with room, otherwise ack is held back
    assign push  = (in_state == IN_WAIT_REQ) && in_link.req && !full;
    // Entry leaves once the serializer acks it
    assign pop   = (out_state == OUT_REQ) && out_link.ack;
    // Offer the head entry
    assign issue = (out_state == OUT_IDLE) && !empty && !out_link.ack;

    // ==========================================================
    // Input side
    // ==========================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            in_state    <= IN_WAIT_REQ;
            in_link.ack <= 1'b0;
            wr_ptr      <= '0;
        end else begin
            case (in_state)
                IN_WAIT_REQ: begin
                    if (push) begin
                        in_link.ack <= 1'b1;
                        wr_ptr      <= (wr_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0
                                       : wr_ptr + 1'b1;
                        in_state    <= IN_WAIT_DROP;
                    end
                end
                IN_WAIT_DROP: begin
                    // Release ack after req goes away
                    if (!in_link.req) begin
                        in_link.ack <= 1'b0;
                        in_state    <= IN_WAIT_REQ;
                    end
                end
                default: in_state <= IN_WAIT_REQ;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            sample_mem[wr_ptr] <= in_link.sample;
            rest_mem[wr_ptr]   <= in_link.rest;
        end
    end

    // Occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (push && !pop) begin
            count <= count + 1'b1;
        end else if (pop && !push) begin
            count <= count - 1'b1;
        end
    end

    // ==========================================================
    // Output side
    // ==========================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            out_state    <= OUT_IDLE;
            out_link.req <= 1'b0;
            rd_ptr       <= '0;
        end else begin
            case (out_state)
                OUT_IDLE: begin
                    if (issue) begin
                        out_link.req <= 1'b1;
                        out_state    <= OUT_REQ;
                    end
                end
                OUT_REQ: begin
                    if (pop) begin
                        out_link.req <= 1'b0;
                        rd_ptr       <= (rd_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0
                                        : rd_ptr + 1'b1;
                        out_state    <= OUT_WAIT;
                    end
                end
                OUT_WAIT: begin
                    if (!out_link.ack) begin
                        out_state <= OUT_IDLE;
                    end
                end
                default: out_state <= OUT_IDLE;
            endcase
        end
    end

    // Head entry copied out when offered
    always_ff @(posedge clk) begin
        if (issue) begin
            out_link.sample <= sample_mem[rd_ptr];
            out_link.rest   <= rest_mem[rd_ptr];
        end
    end

endmodule

/* logic/sample_if.sv */
`timescale 1ns/1ps

// One four-phase sample link
// req up with data stable, ack up, req down, ack down
interface sample_if import music_pkg::*; ();

    // Handshake pair
    logic    req;
    logic    ack;

    // Payload, held stable while req is high
    sample_t sample;
    // Marks a sample made from a rest note
    logic    rest;

    // Producer side of the link
    modport sender (
        output req,
        output sample,
        output rest,
        input  ack
    );

    // Consumer side of the link
    modport receiver (
        input  req,
        input  sample,
        input  rest,
        output ack
    );

endinterface

/* testbench/music_core_chk.sv */
`timescale 1ns/1ps

module music_core_chk import music_pkg::*; (
    input logic    clk,
    input logic    reset,
    input logic    synth_req,
    input logic    synth_ack,
    input sample_t synth_sample,
    input logic    synth_rest,
    input logic    codec_req,
    input logic    codec_ack,
    input sample_t codec_sample,
    input logic    codec_rest
);

    // Hits on any property below
    int fail_count;

    // ==========================================================
    // Synthesizer to FIFO
    // ==========================================================

    synth_req_hold: assert property (@(posedge clk) disable iff (reset)
        synth_req && !synth_ack |=> synth_req)
        else begin
            $error("synth_link req fell before ack");
            fail_count++;
        end

    synth_data_stable: assert property (@(posedge clk) disable iff (reset)
        synth_req |=> !synth_req || $stable({synth_sample, synth_rest}))
        else begin
            $error("synth_link payload changed under req");
            fail_count++;
        end

    synth_ack_cause: assert property (@(posedge clk) disable iff (reset)
        $rose(synth_ack) |-> synth_req)
        else begin
            $error("synth_link ack rose without req");
            fail_count++;
        end

    // ==========================================================
    // FIFO to serializer
    // ==========================================================

    codec_req_hold: assert property (@(posedge clk) disable iff (reset)
        codec_req && !codec_ack |=> codec_req)
        else begin
            $error("codec_link req fell before ack");
            fail_count++;
        end

    codec_data_stable: assert property (@(posedge clk) disable iff (reset)
        codec_req |=> !codec_req || $stable({codec_sample, codec_rest}))
        else begin
            $error("codec_link payload changed under req");
            fail_count++;
        end

    codec_ack_cause: assert property (@(posedge clk) disable iff (reset)
        $rose(codec_ack) |-> codec_req)
        else begin
            $error("codec_link ack rose without req");
            fail_count++;
        end

endmodule

// Watch both links inside the top level
bind music_core_top music_core_chk link_chk (
    .clk          (clk),
    .reset        (reset),
    .synth_req    (synth_link.req),
    .synth_ack    (synth_link.ack),
    .synth_sample (synth_link.sample),
    .synth_rest   (synth_link.rest),
    .codec_req    (codec_link.req),
    .codec_ack    (codec_link.ack),
    .codec_sample (codec_link.sample),
    .codec_rest   (codec_link.rest)
);

/* testbench/music_core_tb.sv */
`timescale 1ns/1ps

module music_core_tb import music_pkg::*; ();

    // ==========================================================
    // Run constants
    // ==========================================================

    localparam int CLK_HALF       = 50;
    localparam int FRAME_CYCLES   = FRAME_BITS * 2 * BCLK_DIV;
    // Long enough for a handful of samples per segment
    localparam int PLAY_CYCLES    = 24;
    localparam int MIN_GOOD       = 2;
    // Limit leaves room over about 40 frames in all
    localparam int TIMEOUT_CYCLES = 60 * FRAME_CYCLES + 500;

    logic                   clk;
    logic                   reset;
    logic                   play;
    logic [NOTE_BITS-1:0]   note;
    logic [WEIGHT_BITS-1:0] weight;
    logic                   bclk;
    logic                   lrclk;
    logic                   sdata;
    logic                   underrun;

    // Frame capture state
    int                     bit_idx;
    int                     last_rise;
    logic                   frame_underrun;
    logic [SLOT_BITS-1:0]   left_slot;
    logic [SLOT_BITS-1:0]   right_slot;
    logic [PHASE_BITS-1:0]  model_phase;
    logic [SAMPLE_BITS-1:0] exp_sample;
    int                     frames_done;
    int                     underrun_frames;
    int                     good_frames;
    int                     cycles;

    music_core_top DUT (
        .clk      (clk),
        .reset    (reset),
        .play     (play),
        .note     (note),
        .weight   (weight),
        .bclk     (bclk),
        .lrclk    (lrclk),
        .sdata    (sdata),
        .underrun (underrun)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ==========================================================
    // Model and checks
    // ==========================================================

    // Triangle from phase, centered, then attenuated by weight
    function automatic logic [SAMPLE_BITS-1:0] expected_sample(
        input logic [PHASE_BITS-1:0]  phase,
        input logic [WEIGHT_BITS-1:0] w
    );
        int half;
        int level;
        half = 1 << (PHASE_BITS - 1);
        // Upper half of the phase runs back down
        if (phase < half) begin
            level = int'(phase);
        end else begin
            level = (2 * half - 1) - int'(phase);
        end
        level = level - half / 2;
        return SAMPLE_BITS'(level >>> w);
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Run stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // Rebuild each frame from sdata at rising bclk
    initial begin
        bit_idx         = 0;
        last_rise       = -1;
        frames_done     = 0;
        underrun_frames = 0;
        good_frames     = 0;
        model_phase     = '0;
        frame_underrun  = 1'b0;
        forever begin
            @(posedge bclk);
            // Full bclk period between rising edges
            if (last_rise >= 0) begin
                check_value("bclk_period", cycles - last_rise, 2 * BCLK_DIV);
            end
            last_rise = cycles;
            if (bit_idx == 0) begin
                frame_underrun = underrun;
                left_slot      = '0;
                right_slot     = '0;
                // Silent frame restarts the waveform
                if (underrun) begin
                    model_phase     = '0;
                    underrun_frames = underrun_frames + 1;
                end
            end else begin
                check_value("underrun", underrun, frame_underrun);
            end
            check_value("lrclk", lrclk, bit_idx >= SLOT_BITS);
            if (bit_idx < SLOT_BITS) begin
                left_slot = {left_slot[SLOT_BITS-2:0], sdata};
            end else begin
                right_slot = {right_slot[SLOT_BITS-2:0], sdata};
            end
            // Left slot complete
            if (bit_idx == SLOT_BITS - 1) begin
                if (frame_underrun) begin
                    check_value("left_slot", left_slot, '0);
                end else begin
                    check_value("left_pad", left_slot[PAD_BITS-1:0], '0);
                    exp_sample = (note == '0) ? '0 : expected_sample(model_phase, weight);
                    check_value("left_sample", left_slot[SLOT_BITS-1:PAD_BITS], exp_sample);
                    model_phase = model_phase + PHASE_BITS'(note * STEP_UNIT);
                    good_frames = good_frames + 1;
                end
            end
            if (bit_idx == FRAME_BITS - 1) begin
                check_value("right_slot", right_slot, '0);
                frames_done = frames_done + 1;
                bit_idx     = 0;
            end else begin
                bit_idx = bit_idx + 1;
            end
        end
    end

    // Cycle watchdog that also picks up handshake assertion hits
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (DUT.link_chk.fail_count != 0) begin
                fail_run("A handshake assertion on a sample link failed");
            end
            if (cycles > TIMEOUT_CYCLES) begin
                fail_run("Run did not finish within the cycle limit");
            end
        end
    end

    // ==========================================================
    // Stimulus
    // ==========================================================

    task automatic wait_frames(input int n);
        int target;
        target = frames_done + n;
        while (frames_done < target) begin
            @(posedge clk);
        end
    endtask

    // One burst of play followed by a drain to the next silent frame
    task automatic play_segment(input int n, input int w);
        int good_before;
        int seen;
        good_before = good_frames;
        note        <= NOTE_BITS'(n);
        weight      <= WEIGHT_BITS'(w);
        play        <= 1'b1;
        repeat (PLAY_CYCLES) @(posedge clk);
        play <= 1'b0;
        seen = underrun_frames;
        while (underrun_frames == seen) begin
            @(posedge clk);
        end
        if (good_frames - good_before < MIN_GOOD) begin
            fail_run($sformatf("Note %0d weight %0d produced too few sample frames", n, w));
        end
    endtask

    initial begin
        reset  = 1'b1;
        play   = 1'b0;
        note   = '0;
        weight = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // Only silent frames while the link is idle
        wait_frames(3);
        check_value("underrun_frames", underrun_frames, 3);
        check_value("good_frames", good_frames, 0);

        // Same note at three weights
        play_segment(5, 0);
        play_segment(5, 1);
        play_segment(5, 3);
        // Rest note
        play_segment(0, 0);
        // Restart on a new note
        play_segment(9, 2);

        if (DUT.link_chk.fail_count != 0) begin
            fail_run("A handshake assertion on a sample link failed");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule
